// File: compile.f
src/mem_dbg_pkg.sv
src/mem_dbg_if.sv
src/dbg_axil_regs.sv
src/bank_access_ctrl.sv
src/bank_array.sv
src/mem_dbg_top.sv
testbench/mem_dbg_assertions.sv
testbench/mem_dbg_checker.sv
testbench/tb_mem_dbg.sv

// File: src/bank_access_ctrl.sv
// Bank access controller; decodes the lane select and runs the read and write pipelines
`timescale 1ns/100ps

module bank_access_ctrl #(
    parameter int ADDR_W = mem_dbg_pkg::DEF_ADDR_W
) (
    input  logic    clk,
    input  logic    rstn,
    dbg_req_if.ctrl req,
    bank_if.ctrl    bank
);
    import mem_dbg_pkg::*;

    localparam int LANE_IDX_W = $clog2(LANES_PER_WORD);
    localparam int BANK_IDX_W = SEL_W - LANE_IDX_W;

    logic [BANK_IDX_W-1:0] sel_bank;
    logic [LANE_IDX_W-1:0] sel_lane;
    logic                  sel_valid;
    logic [NUM_BANKS-1:0]  bank_dec;

    logic                  rd_v1;
    logic                  rd_v2;
    logic                  rd_v3;
    logic                  wr_v1;
    logic [BANK_IDX_W-1:0] rd_bank_q1;
    logic [BANK_IDX_W-1:0] rd_bank_q2;
    logic [LANE_IDX_W-1:0] rd_lane_q1;
    logic [LANE_IDX_W-1:0] rd_lane_q2;
    logic [LANE_IDX_W-1:0] rd_lane_q3;
    logic                  rd_ok_q1;
    logic                  rd_ok_q2;
    logic [WORD_W-1:0]     word_q;

    assign sel_bank  = req.sel[SEL_W-1:LANE_IDX_W];
    assign sel_lane  = req.sel[LANE_IDX_W-1:0];
    assign sel_valid = sel_bank < NUM_BANKS;

    // Selects 96 and up leave every bank off
    always_comb begin
        bank_dec = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (sel_bank == i) begin
                bank_dec[i] = 1'b1;
            end
        end
    end

    // --------------------
    // Bank request stage
    // --------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            bank.chip_en   <= '0;
            bank.wr_en     <= 1'b0;
            bank.lane_mask <= '0;
            bank.addr      <= '0;
        end else begin
            bank.chip_en   <= (req.start_rd || req.start_wr) ? bank_dec : '0;
            bank.wr_en     <= req.start_wr;
            bank.lane_mask <= req.start_wr ? LANES_PER_WORD'(1) << sel_lane : '0;
            if (req.start_rd || req.start_wr) begin
                bank.addr <= req.addr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.start_wr) begin
            bank.wdata <= {LANES_PER_WORD{req.wdata}};
        end
    end

    // --------------------
    // Stage valids and done
    // --------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_v1    <= 1'b0;
            rd_v2    <= 1'b0;
            rd_v3    <= 1'b0;
            wr_v1    <= 1'b0;
            req.done <= 1'b0;
        end else begin
            rd_v1    <= req.start_rd;
            rd_v2    <= rd_v1;
            rd_v3    <= rd_v2;
            wr_v1    <= req.start_wr;
            req.done <= rd_v3 || wr_v1;
        end
    end

    // Read data path, bank word first and lane one cycle later
    always_ff @(posedge clk) begin
        if (req.start_rd) begin
            rd_bank_q1 <= sel_bank;
            rd_lane_q1 <= sel_lane;
            rd_ok_q1   <= sel_valid;
        end
        if (rd_v1) begin
            rd_bank_q2 <= rd_bank_q1;
            rd_lane_q2 <= rd_lane_q1;
            rd_ok_q2   <= rd_ok_q1;
        end
        if (rd_v2) begin
            word_q     <= rd_ok_q2 ? bank.rdata[rd_bank_q2] : '0;
            rd_lane_q3 <= rd_lane_q2;
        end
        if (rd_v3) begin
            req.rd_data <= word_q[rd_lane_q3*LANE_W +: LANE_W];
        end
    end

endmodule

// File: src/bank_array.sv
// Packet buffer model of 24 banks with per-lane writes and a registered read port per bank
`timescale 1ns/100ps

module bank_array #(
    parameter int ADDR_W = mem_dbg_pkg::DEF_ADDR_W
) (
    input  logic clk,
    input  logic rstn,
    bank_if.mem  bank
);
    import mem_dbg_pkg::*;

    localparam int DEPTH = 2 ** ADDR_W;

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        logic [WORD_W-1:0] mem [DEPTH];
        logic [WORD_W-1:0] rd_q;

        // Contents cleared by reset
        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                for (int w = 0; w < DEPTH; w++) begin
                    mem[w] <= '0;
                end
            end else if (bank.chip_en[b] && bank.wr_en) begin
                for (int l = 0; l < LANES_PER_WORD; l++) begin
                    if (bank.lane_mask[l]) begin
                        mem[bank.addr][l*LANE_W +: LANE_W] <= bank.wdata[l*LANE_W +: LANE_W];
                    end
                end
            end
        end

        // Output holds while the bank is idle
        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                rd_q <= '0;
            end else if (bank.chip_en[b]) begin
                rd_q <= mem[bank.addr];
            end
        end

        assign bank.rdata[b] = rd_q;
    end

endmodule

// File: src/dbg_axil_regs.sv
// AXI4-Lite register block of the memory debug unit; holds the setup and issues debug commands
`timescale 1ns/100ps

module dbg_axil_regs #(
    parameter int ADDR_W = mem_dbg_pkg::DEF_ADDR_W
) (
    input  logic        clk,
    input  logic        rstn,

    input  logic        awvalid,
    output logic        awready,
    input  logic [5:0]  awaddr,
    input  logic        wvalid,
    output logic        wready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    output logic        bvalid,
    input  logic        bready,
    output logic [1:0]  bresp,

    input  logic        arvalid,
    output logic        arready,
    input  logic [5:0]  araddr,
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,

    dbg_req_if.regs     req
);
    import mem_dbg_pkg::*;

    logic [SEL_W-1:0]  sel_q;
    logic [ADDR_W-1:0] addr_q;
    logic [LANE_W-1:0] wdata_q;
    logic [LANE_W-1:0] rdata_q;
    logic [SEL_W-1:0]  sel_hold;
    logic [ADDR_W-1:0] addr_hold;
    logic [LANE_W-1:0] wdata_hold;
    logic              busy;
    logic              op_is_rd;

    logic              wr_hs;
    logic              rd_hs;
    logic              cmd_go;
    logic [31:0]       wr_old;
    logic [31:0]       wr_merged;
    logic [1:0]        wr_resp;
    logic [31:0]       rd_word;
    logic [1:0]        rd_resp;

    function automatic logic [31:0] apply_strb(input logic [31:0] old_v,
                                               input logic [31:0] new_v,
                                               input logic [3:0]  strb);
        logic [31:0] res;
        for (int b = 0; b < 4; b++) begin
            res[b*8 +: 8] = strb[b] ? new_v[b*8 +: 8] : old_v[b*8 +: 8];
        end
        return res;
    endfunction

    // --------------------
    // Write channel
    // --------------------
    assign wready    = awready;
    assign wr_hs     = awready && awvalid && wvalid;
    assign wr_merged = apply_strb(wr_old, wdata, wstrb);

    always_comb begin
        wr_old  = '0;
        wr_resp = RESP_SLVERR;
        case (awaddr)
            REG_SEL: begin
                wr_old  = 32'(sel_q);
                wr_resp = RESP_OKAY;
            end
            REG_ADDR: begin
                wr_old  = 32'(addr_q);
                wr_resp = RESP_OKAY;
            end
            REG_WDATA: begin
                wr_old  = 32'(wdata_q);
                wr_resp = RESP_OKAY;
            end
            REG_CMD: wr_resp = busy ? RESP_SLVERR : RESP_OKAY;
            default: wr_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            awready <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= RESP_OKAY;
        end else begin
            // One-cycle ready, no new write while a response waits
            awready <= awvalid && wvalid && !awready && !bvalid;
            if (wr_hs) begin
                bvalid <= 1'b1;
                bresp  <= wr_resp;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sel_q   <= '0;
            addr_q  <= '0;
            wdata_q <= '0;
        end else if (wr_hs && wr_resp == RESP_OKAY) begin
            case (awaddr)
                REG_SEL:   sel_q   <= wr_merged[SEL_W-1:0];
                REG_ADDR:  addr_q  <= wr_merged[ADDR_W-1:0];
                REG_WDATA: wdata_q <= wr_merged[LANE_W-1:0];
                default:   ;
            endcase
        end
    end

    // --------------------
    // Command issue
    // --------------------
    assign cmd_go       = wr_hs && awaddr == REG_CMD && !busy && wstrb[0];
    assign req.start_rd = cmd_go && wdata[0];
    assign req.start_wr = cmd_go && wdata[1] && !wdata[0];

    // Operands frozen for the controller until done
    assign req.sel   = busy ? sel_hold : sel_q;
    assign req.addr  = busy ? addr_hold : addr_q;
    assign req.wdata = busy ? wdata_hold : wdata_q;

    always_ff @(posedge clk) begin
        if (req.start_rd || req.start_wr) begin
            sel_hold   <= sel_q;
            addr_hold  <= addr_q;
            wdata_hold <= wdata_q;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy     <= 1'b0;
            op_is_rd <= 1'b0;
            rdata_q  <= '0;
        end else begin
            if (req.start_rd || req.start_wr) begin
                busy     <= 1'b1;
                op_is_rd <= req.start_rd;
            end else if (req.done) begin
                busy <= 1'b0;
            end
            if (req.done && op_is_rd) begin
                rdata_q <= req.rd_data;
            end
        end
    end

    // --------------------
    // Read channel
    // --------------------
    assign rd_hs = arready && arvalid;

    always_comb begin
        rd_word = '0;
        rd_resp = RESP_OKAY;
        case (araddr)
            REG_SEL:    rd_word = 32'(sel_q);
            REG_ADDR:   rd_word = 32'(addr_q);
            REG_WDATA:  rd_word = 32'(wdata_q);
            REG_CMD:    rd_word = '0;
            REG_RDATA:  rd_word = 32'(rdata_q);
            REG_STATUS: rd_word = 32'(busy);
            default:    rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= RESP_OKAY;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rd_hs) begin
                rvalid <= 1'b1;
                rdata  <= rd_word;
                rresp  <= rd_resp;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

// File: src/mem_dbg_if.sv
// Internal buses of the memory debug unit, the debug request path and the bank access path
`timescale 1ns/100ps

// Register block to controller
interface dbg_req_if #(
    parameter int ADDR_W = mem_dbg_pkg::DEF_ADDR_W
) ();
    import mem_dbg_pkg::*;

    logic              start_rd;
    logic              start_wr;
    logic [SEL_W-1:0]  sel;
    logic [ADDR_W-1:0] addr;
    logic [LANE_W-1:0] wdata;
    // Valid only while done is high
    logic [LANE_W-1:0] rd_data;
    logic              done;

    modport regs (
        output start_rd, start_wr, sel, addr, wdata,
        input  rd_data, done
    );

    modport ctrl (
        input  start_rd, start_wr, sel, addr, wdata,
        output rd_data, done
    );
endinterface

// Controller to bank array
interface bank_if #(
    parameter int ADDR_W = mem_dbg_pkg::DEF_ADDR_W
) ();
    import mem_dbg_pkg::*;

    logic [NUM_BANKS-1:0]      chip_en;
    logic                      wr_en;
    logic [LANES_PER_WORD-1:0] lane_mask;
    logic [ADDR_W-1:0]         addr;
    // Write lane copied into every lane position
    logic [WORD_W-1:0]         wdata;
    logic [WORD_W-1:0]         rdata [NUM_BANKS];

    modport ctrl (
        output chip_en, wr_en, lane_mask, addr, wdata,
        input  rdata
    );

    modport mem (
        input  chip_en, wr_en, lane_mask, addr, wdata,
        output rdata
    );
endinterface

// File: src/mem_dbg_pkg.sv
// Shared constants for the memory debug unit; imported by the interfaces and RTL blocks
package mem_dbg_pkg;

    // --------------------
    // Bank geometry
    // --------------------
    localparam int NUM_BANKS      = 24;
    localparam int LANE_W         = 9;
    localparam int LANES_PER_WORD = 4;
    localparam int WORD_W         = LANE_W * LANES_PER_WORD;

    // Upper bits pick the bank, lowest two the lane
    localparam int SEL_W          = 7;

    // Word address width unless the top level overrides it
    localparam int DEF_ADDR_W     = 6;

    // --------------------
    // Register map
    // --------------------
    localparam logic [5:0] REG_SEL    = 6'h00;
    localparam logic [5:0] REG_ADDR   = 6'h04;
    localparam logic [5:0] REG_WDATA  = 6'h08;
    // Bit 0 starts a read, bit 1 a write
    localparam logic [5:0] REG_CMD    = 6'h0C;
    localparam logic [5:0] REG_RDATA  = 6'h10;
    // Bit 0 is busy
    localparam logic [5:0] REG_STATUS = 6'h14;

    // --------------------
    // AXI response codes
    // --------------------
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: src/mem_dbg_top.sv
// Top level of the memory debug unit; AXI4-Lite slave in front of the bank controller and banks
`timescale 1ns/100ps

module mem_dbg_top #(
    parameter int ADDR_W = mem_dbg_pkg::DEF_ADDR_W
) (
    input  logic        clk,
    input  logic        rstn,

    input  logic        awvalid,
    output logic        awready,
    input  logic [5:0]  awaddr,
    input  logic        wvalid,
    output logic        wready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    output logic        bvalid,
    input  logic        bready,
    output logic [1:0]  bresp,

    input  logic        arvalid,
    output logic        arready,
    input  logic [5:0]  araddr,
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp
);

    dbg_req_if #(.ADDR_W(ADDR_W)) req_bus ();
    bank_if    #(.ADDR_W(ADDR_W)) bank_bus ();

    dbg_axil_regs #(
        .ADDR_W (ADDR_W)
    ) regs_i (
        .clk     (clk),
        .rstn    (rstn),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .req     (req_bus.regs)
    );

    bank_access_ctrl #(
        .ADDR_W (ADDR_W)
    ) ctrl_i (
        .clk  (clk),
        .rstn (rstn),
        .req  (req_bus.ctrl),
        .bank (bank_bus.ctrl)
    );

    bank_array #(
        .ADDR_W (ADDR_W)
    ) banks_i (
        .clk  (clk),
        .rstn (rstn),
        .bank (bank_bus.mem)
    );

endmodule

// File: testbench/mem_dbg_assertions.sv
// Concurrent checks on bank enables, the done pulse and AXI response stability, bound into the RTL
`timescale 1ns/100ps

module mem_dbg_assertions (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic [mem_dbg_pkg::NUM_BANKS-1:0] chip_en,
    input  logic                             start,
    input  logic                             done,
    input  logic                             bvalid,
    input  logic                             bready,
    input  logic [1:0]                       bresp,
    input  logic                             rvalid,
    input  logic                             rready,
    input  logic [31:0]                      rdata,
    input  logic [1:0]                       rresp
);

    int sva_errors = 0;

    chip_en_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(chip_en))
        else begin
            sva_errors++;
            $error("chip_en has more than one bank enabled");
        end

    // Read done follows start by 4 cycles, write done by 2
    done_after_start: assert property (@(posedge clk) disable iff (!rstn)
        done |-> ($past(start, 2) || $past(start, 4)))
        else begin
            sva_errors++;
            $error("done pulsed without a matching start");
        end

    b_stable: assert property (@(posedge clk) disable iff (!rstn)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            sva_errors++;
            $error("write response changed before it was accepted");
        end

    r_stable: assert property (@(posedge clk) disable iff (!rstn)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            sva_errors++;
            $error("read response changed before it was accepted");
        end

endmodule

bind bank_access_ctrl mem_dbg_assertions ctrl_sva_i (
    .clk     (clk),
    .rstn    (rstn),
    .chip_en (bank.chip_en),
    .start   (req.start_rd || req.start_wr),
    .done    (req.done),
    .bvalid  (1'b0),
    .bready  (1'b0),
    .bresp   (2'b00),
    .rvalid  (1'b0),
    .rready  (1'b0),
    .rdata   (32'h0),
    .rresp   (2'b00)
);

bind dbg_axil_regs mem_dbg_assertions regs_sva_i (
    .clk     (clk),
    .rstn    (rstn),
    .chip_en ('0),
    .start   (1'b0),
    .done    (1'b0),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp)
);

// File: testbench/mem_dbg_checker.sv
// Testbench monitor on the AXI4-Lite ports; compares responses with the expected values from the model
`timescale 1ns/100ps

module mem_dbg_checker (
    input  logic        clk,
    input  logic        rstn,
    input  logic        awvalid,
    input  logic        awready,
    input  logic        wready,
    input  logic [5:0]  awaddr,
    input  logic        bvalid,
    input  logic        bready,
    input  logic [1:0]  bresp,
    input  logic        arvalid,
    input  logic        arready,
    input  logic [5:0]  araddr,
    input  logic        rvalid,
    input  logic        rready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic [1:0]  exp_bresp,
    input  logic        check_rdata,
    input  logic [31:0] exp_rdata,
    input  logic [1:0]  exp_rresp
);

    int         mismatches = 0;
    int         checks = 0;
    logic [5:0] last_awaddr;
    logic [5:0] last_araddr;

    // Address of the transaction whose response comes next
    always @(posedge clk) begin
        if (awvalid && awready) begin
            last_awaddr <= awaddr;
        end
        if (arvalid && arready) begin
            last_araddr <= araddr;
        end
    end

    always @(posedge clk) begin
        // Address and data are accepted in the same cycle
        if (rstn && awready !== wready) begin
            mismatches++;
            $display("** Error @%0t: awready %0b and wready %0b differ",
                     $time, awready, wready);
        end
        if (rstn && bvalid && bready) begin
            checks++;
            if (bresp !== exp_bresp) begin
                mismatches++;
                $display("** Error @%0t: write to 0x%02h answered %0d, expected %0d",
                         $time, last_awaddr, bresp, exp_bresp);
            end
        end
        if (rstn && rvalid && rready) begin
            checks++;
            if (rresp !== exp_rresp) begin
                mismatches++;
                $display("** Error @%0t: read of 0x%02h answered %0d, expected %0d",
                         $time, last_araddr, rresp, exp_rresp);
            end else if (check_rdata && rdata !== exp_rdata) begin
                mismatches++;
                $display("** Error @%0t: read of 0x%02h returned 0x%08h, expected 0x%08h",
                         $time, last_araddr, rdata, exp_rdata);
            end
        end
    end

    task automatic report_counts(input int timeouts, input int sva_fails, output int total);
        total = mismatches + timeouts + sva_fails;
        $display("Checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
                 checks, mismatches, timeouts, sva_fails);
    endtask

endmodule

// File: testbench/tb_mem_dbg.sv
// Testbench top; drives random lane reads and writes over AXI4-Lite and keeps the bank model
`timescale 1ns/100ps

module tb_mem_dbg;
    import mem_dbg_pkg::*;

    localparam int ADDR_W     = DEF_ADDR_W;
    localparam int DEPTH      = 2 ** ADDR_W;
    localparam int NUM_OPS    = 300;
    localparam int HS_LIMIT   = 50;
    localparam int POLL_LIMIT = 40;

    logic        clk;
    logic        rstn;
    logic        awvalid;
    logic        awready;
    logic [5:0]  awaddr;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        arvalid;
    logic        arready;
    logic [5:0]  araddr;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;

    logic [1:0]  exp_bresp;
    logic [1:0]  exp_rresp;
    logic [31:0] exp_rdata;
    logic        check_rdata;

    int          seed;
    int          timeouts = 0;
    longint      cycle = 0;
    longint      cmd_cycle = -100;
    int          cmd_latency = 0;

    // Reference banks and the expected REG_RDATA
    logic [WORD_W-1:0] model_mem [NUM_BANKS][DEPTH];
    logic [LANE_W-1:0] model_rdata;

    mem_dbg_top #(.ADDR_W(ADDR_W)) dut_i (
        .clk     (clk),
        .rstn    (rstn),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    mem_dbg_checker chk_i (
        .clk         (clk),
        .rstn        (rstn),
        .awvalid     (awvalid),
        .awready     (awready),
        .wready      (wready),
        .awaddr      (awaddr),
        .bvalid      (bvalid),
        .bready      (bready),
        .bresp       (bresp),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .rresp       (rresp),
        .exp_bresp   (exp_bresp),
        .check_rdata (check_rdata),
        .exp_rdata   (exp_rdata),
        .exp_rresp   (exp_rresp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // --------------------
    // Model
    // --------------------
    // Busy from the edge after the CMD handshake through the done cycle
    function automatic logic unit_busy(input longint at);
        return (at - cmd_cycle) >= 1 && (at - cmd_cycle) <= cmd_latency;
    endfunction

    function automatic logic [LANE_W-1:0] model_lane(input logic [SEL_W-1:0] sel,
                                                     input logic [ADDR_W-1:0] addr);
        int bank;
        int lane;
        bank = sel >> 2;
        lane = sel & 3;
        if (bank >= NUM_BANKS) begin
            return '0;
        end
        return model_mem[bank][addr][lane*LANE_W +: LANE_W];
    endfunction

    function automatic void model_apply(input logic is_rd, input logic [SEL_W-1:0] sel,
                                        input logic [ADDR_W-1:0] addr,
                                        input logic [LANE_W-1:0] data);
        int bank;
        int lane;
        bank = sel >> 2;
        lane = sel & 3;
        if (is_rd) begin
            model_rdata = model_lane(sel, addr);
        end else if (bank < NUM_BANKS) begin
            model_mem[bank][addr][lane*LANE_W +: LANE_W] = data;
        end
    endfunction

    // --------------------
    // AXI4-Lite driver
    // --------------------
    // Both tasks start on the edge where the previous transfer ended
    task automatic reg_write(input logic [5:0] addr, input logic [31:0] data,
                             input logic [1:0] resp_exp, output logic ok);
        int         n;
        logic [1:0] want;
        ok = 1'b0;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= 4'hF;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!awready && n < HS_LIMIT);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        if (!awready) begin
            $display("Timeout: write to 0x%02h was never accepted", addr);
            timeouts++;
            return;
        end
        want = resp_exp;
        if (addr == REG_CMD) begin
            want = unit_busy(cycle) ? RESP_SLVERR : RESP_OKAY;
            if (want == RESP_OKAY) begin
                cmd_cycle   = cycle;
                cmd_latency = data[0] ? 4 : 2;
            end
        end
        exp_bresp <= want;
        ok = (want == RESP_OKAY);
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (bvalid && !bready) begin
                bready <= 1'b1;
            end
        end while (!(bvalid && bready) && n < HS_LIMIT);
        if (!(bvalid && bready)) begin
            $display("Timeout: no write response for 0x%02h", addr);
            timeouts++;
        end
        bready <= 1'b0;
    endtask

    task automatic reg_read(input logic [5:0] addr, input logic [31:0] data_exp,
                            input logic check, input logic [1:0] resp_exp,
                            output logic [31:0] data);
        int n;
        data = '0;
        arvalid     <= 1'b1;
        araddr      <= addr;
        exp_rdata   <= data_exp;
        exp_rresp   <= resp_exp;
        check_rdata <= check;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!arready && n < HS_LIMIT);
        arvalid <= 1'b0;
        if (!arready) begin
            $display("Timeout: read of 0x%02h was never accepted", addr);
            timeouts++;
            return;
        end
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (rvalid && !rready) begin
                rready <= 1'b1;
            end
        end while (!(rvalid && rready) && n < HS_LIMIT);
        if (rvalid && rready) begin
            data = rdata;
        end else begin
            $display("Timeout: no read response for 0x%02h", addr);
            timeouts++;
        end
        rready <= 1'b0;
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        int          n;
        n = 0;
        do begin
            reg_read(REG_STATUS, 32'h0, 1'b0, RESP_OKAY, st);
            n++;
        end while (st[0] && n < POLL_LIMIT);
        if (st[0]) begin
            $display("Timeout: unit still busy after %0d status polls", n);
            timeouts++;
        end
    endtask

    // --------------------
    // Operations
    // --------------------
    task automatic run_op(input logic is_rd, input logic [SEL_W-1:0] sel,
                          input logic [ADDR_W-1:0] addr, input logic [LANE_W-1:0] data);
        logic        ok;
        logic        again_rd;
        logic [31:0] junk;
        logic [31:0] rd;
        junk = $random(seed);
        // Upper junk bits must be dropped by the registers
        reg_write(REG_SEL, {junk[31:SEL_W], sel}, RESP_OKAY, ok);
        reg_write(REG_ADDR, {junk[31:ADDR_W], addr}, RESP_OKAY, ok);
        reg_write(REG_WDATA, {junk[31:LANE_W], data}, RESP_OKAY, ok);
        reg_write(REG_CMD, is_rd ? 32'h1 : 32'h2, RESP_OKAY, ok);
        if (ok) begin
            model_apply(is_rd, sel, addr, data);
        end
        // Second command right behind the first
        if (($random(seed) & 3) == 0) begin
            again_rd = $random(seed);
            reg_write(REG_CMD, again_rd ? 32'h1 : 32'h2, RESP_OKAY, ok);
            if (ok) begin
                model_apply(again_rd, sel, addr, data);
            end
        end
        wait_idle();
        reg_read(REG_RDATA, 32'(model_rdata), 1'b1, RESP_OKAY, rd);
        if (($random(seed) & 7) == 0) begin
            reg_read(REG_SEL, 32'(sel), 1'b1, RESP_OKAY, rd);
            reg_read(REG_ADDR, 32'(addr), 1'b1, RESP_OKAY, rd);
            reg_read(REG_WDATA, 32'(data), 1'b1, RESP_OKAY, rd);
        end
    endtask

    task automatic check_bad_access();
        logic        ok;
        logic [31:0] rd;
        reg_write(REG_RDATA, 32'h1FF, RESP_SLVERR, ok);
        reg_write(REG_STATUS, 32'h1, RESP_SLVERR, ok);
        reg_write(6'h18, 32'hFFFF, RESP_SLVERR, ok);
        reg_write(6'h3C, 32'h5A5A, RESP_SLVERR, ok);
        reg_read(6'h20, 32'h0, 1'b1, RESP_SLVERR, rd);
        reg_read(REG_RDATA, 32'(model_rdata), 1'b1, RESP_OKAY, rd);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        logic              is_rd;
        logic [SEL_W-1:0]  sel;
        logic [SEL_W-1:0]  nb;
        logic [ADDR_W-1:0] addr;
        logic [LANE_W-1:0] data;
        int                sva_fails;
        int                total;

        seed = 32'h67943aee;
        rstn        <= 1'b0;
        awvalid     <= 1'b0;
        awaddr      <= '0;
        wvalid      <= 1'b0;
        wdata       <= '0;
        wstrb       <= '0;
        bready      <= 1'b0;
        arvalid     <= 1'b0;
        araddr      <= '0;
        rready      <= 1'b0;
        exp_bresp   <= RESP_OKAY;
        exp_rresp   <= RESP_OKAY;
        exp_rdata   <= '0;
        check_rdata <= 1'b0;
        model_rdata = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int w = 0; w < DEPTH; w++) begin
                model_mem[b][w] = '0;
            end
        end
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        repeat (2) @(posedge clk);

        // Banks are fresh after reset
        for (int i = 0; i < 8; i++) begin
            run_op(1'b1, SEL_W'($random(seed)), ADDR_W'($random(seed)), '0);
        end
        check_bad_access();

        for (int i = 0; i < NUM_OPS; i++) begin
            is_rd = $random(seed);
            sel   = SEL_W'($random(seed));
            addr  = ($random(seed) & 1) ? ADDR_W'($random(seed)) : ADDR_W'({$random(seed)} % 4);
            data  = LANE_W'($random(seed));
            run_op(is_rd, sel, addr, data);
            if (!is_rd) begin
                // Written lane, then another lane of the same word
                nb = sel ^ SEL_W'(1 + {$random(seed)} % 3);
                run_op(1'b1, sel, addr, '0);
                run_op(1'b1, nb, addr, '0);
            end
        end
        check_bad_access();

        repeat (5) @(posedge clk);
        sva_fails = dut_i.regs_i.regs_sva_i.sva_errors + dut_i.ctrl_i.ctrl_sva_i.sva_errors;
        chk_i.report_counts(timeouts, sva_fails, total);
        if (total == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
